//--- design/vc_router_pkg.sv
// router package holding the direction encoding and the port count
`default_nettype none

package vc_router_pkg;

  // physical ports, four neighbours and one local
  localparam int NumPorts = 5;

  // width of a direction code
  localparam int DirWidth = 3;

  // port directions
  // doubles as the result of XY route computation and as the port index
  typedef enum logic [DirWidth-1:0] {
    N = 3'd0,
    E = 3'd1,
    S = 3'd2,
    W = 3'd3,
    L = 3'd4
  } route_dir_e;

endpackage

`default_nettype wire

//--- design/vc_input_port.sv
// router input port with per-VC flit FIFOs, XY route of each head and credit return
`timescale 1ns/1ps
`default_nettype none

module vc_input_port import vc_router_pkg::*; #(
  parameter int NumVC         = 2,
  parameter int VCDepth       = 2,
  parameter int CoordWidth    = 3,
  parameter int PayloadWidth  = 16,
  localparam int VcWidth      = (NumVC > 1) ? $clog2(NumVC) : 1
) (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  // flit from upstream
  input  logic                                      data_v_i,
  input  logic [VcWidth-1:0]                        data_vc_i,
  input  logic [CoordWidth-1:0]                     data_dst_x_i,
  input  logic [CoordWidth-1:0]                     data_dst_y_i,
  input  logic [PayloadWidth-1:0]                   data_payload_i,
  // own coordinate
  input  logic [CoordWidth-1:0]                     xy_id_x_i,
  input  logic [CoordWidth-1:0]                     xy_id_y_i,
  // pop from switch allocation
  input  logic                                      pop_i,
  input  logic [VcWidth-1:0]                        pop_vc_i,
  // credit back to upstream
  output logic                                      credit_v_o,
  output logic [VcWidth-1:0]                        credit_vc_o,
  // head flit of every VC
  output logic [NumVC-1:0]                          head_v_o,
  output route_dir_e [NumVC-1:0]                    head_dir_o,
  output logic [NumVC-1:0][CoordWidth-1:0]          head_dst_x_o,
  output logic [NumVC-1:0][CoordWidth-1:0]          head_dst_y_o,
  output logic [NumVC-1:0][PayloadWidth-1:0]        head_payload_o
);

  localparam int PtrWidth = (VCDepth > 1) ? $clog2(VCDepth) : 1;
  localparam int CntWidth = $clog2(VCDepth + 1);

  // flit storage, one circular buffer per VC
  logic [CoordWidth-1:0]   mem_x_q   [NumVC][VCDepth];
  logic [CoordWidth-1:0]   mem_y_q   [NumVC][VCDepth];
  logic [PayloadWidth-1:0] mem_pld_q [NumVC][VCDepth];

  logic [PtrWidth-1:0]     wr_ptr_q  [NumVC];
  logic [PtrWidth-1:0]     rd_ptr_q  [NumVC];
  logic [CntWidth-1:0]     cnt_q     [NumVC];

  logic [NumVC-1:0]        push;
  logic [NumVC-1:0]        pop;

  // wrap at the buffer end
  function automatic logic [PtrWidth-1:0] ptr_inc(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(VCDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_comb begin
    for (int v = 0; v < NumVC; v++) begin
      push[v] = data_v_i && (data_vc_i == VcWidth'(v));
      pop[v]  = pop_i && (pop_vc_i == VcWidth'(v));
    end
  end

  // write side, the flit lands in the FIFO of its own VC
  always_ff @(posedge clk_i) begin
    if (data_v_i) begin
      mem_x_q[data_vc_i][wr_ptr_q[data_vc_i]]   <= data_dst_x_i;
      mem_y_q[data_vc_i][wr_ptr_q[data_vc_i]]   <= data_dst_y_i;
      mem_pld_q[data_vc_i][wr_ptr_q[data_vc_i]] <= data_payload_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int v = 0; v < NumVC; v++) begin
        wr_ptr_q[v] <= '0;
        rd_ptr_q[v] <= '0;
        cnt_q[v]    <= '0;
      end
    end else begin
      for (int v = 0; v < NumVC; v++) begin
        if (push[v]) begin
          wr_ptr_q[v] <= ptr_inc(wr_ptr_q[v]);
        end
        if (pop[v]) begin
          rd_ptr_q[v] <= ptr_inc(rd_ptr_q[v]);
        end
        // push and pop together keep the fill level
        if (push[v] && !pop[v]) begin
          cnt_q[v] <= cnt_q[v] + 1'b1;
        end else if (pop[v] && !push[v]) begin
          cnt_q[v] <= cnt_q[v] - 1'b1;
        end
      end
    end
  end

  // head view and XY route per VC
  always_comb begin
    for (int v = 0; v < NumVC; v++) begin
      head_v_o[v]       = (cnt_q[v] != '0);
      head_dst_x_o[v]   = mem_x_q[v][rd_ptr_q[v]];
      head_dst_y_o[v]   = mem_y_q[v][rd_ptr_q[v]];
      head_payload_o[v] = mem_pld_q[v][rd_ptr_q[v]];
      // x first, then y, else eject locally
      if (mem_x_q[v][rd_ptr_q[v]] > xy_id_x_i) begin
        head_dir_o[v] = E;
      end else if (mem_x_q[v][rd_ptr_q[v]] < xy_id_x_i) begin
        head_dir_o[v] = W;
      end else if (mem_y_q[v][rd_ptr_q[v]] > xy_id_y_i) begin
        head_dir_o[v] = N;
      end else if (mem_y_q[v][rd_ptr_q[v]] < xy_id_y_i) begin
        head_dir_o[v] = S;
      end else begin
        head_dir_o[v] = L;
      end
    end
  end

  // one credit upstream per popped flit, in step with the output register
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_v_o  <= 1'b0;
      credit_vc_o <= '0;
    end else begin
      credit_v_o  <= pop_i;
      credit_vc_o <= pop_vc_i;
    end
  end

endmodule

`default_nettype wire

//--- design/vc_sa_local.sv
// local switch allocator that picks one eligible VC of an input port round-robin
`timescale 1ns/1ps
`default_nettype none

module vc_sa_local import vc_router_pkg::*; #(
  parameter int NumVC    = 2,
  localparam int VcWidth = (NumVC > 1) ? $clog2(NumVC) : 1
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic [NumVC-1:0]                  head_v_i,
  input  route_dir_e [NumVC-1:0]            head_dir_i,
  // credit availability per output port per VC
  input  logic [NumPorts-1:0][NumVC-1:0]    credit_avail_i,
  // global stage accepted this port's request
  input  logic                              granted_i,
  output logic                              req_v_o,
  output logic [NumPorts-1:0]               req_dir_oh_o,
  output logic [VcWidth-1:0]                req_vc_o
);

  // last granted VC
  logic [VcWidth-1:0] ptr_q;
  logic [NumVC-1:0]   eligible;

  // head present and a downstream slot on the same VC id
  always_comb begin
    for (int v = 0; v < NumVC; v++) begin
      eligible[v] = head_v_i[v] && credit_avail_i[head_dir_i[v]][v];
    end
  end

  // search starts right after the last winner
  always_comb begin
    int idx;
    req_v_o  = 1'b0;
    req_vc_o = '0;
    for (int i = 1; i <= NumVC; i++) begin
      idx = (int'(ptr_q) + i) % NumVC;
      if (!req_v_o && eligible[idx]) begin
        req_v_o  = 1'b1;
        req_vc_o = VcWidth'(idx);
      end
    end
    req_dir_oh_o = '0;
    if (req_v_o) begin
      req_dir_oh_o[head_dir_i[req_vc_o]] = 1'b1;
    end
  end

  // a losing request keeps its priority
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q <= VcWidth'(NumVC - 1);
    end else if (granted_i) begin
      ptr_q <= req_vc_o;
    end
  end

endmodule

`default_nettype wire

//--- design/vc_sa_global.sv
// global switch allocator that picks one requesting input per output port round-robin
`timescale 1ns/1ps
`default_nettype none

module vc_sa_global import vc_router_pkg::*; #(
  parameter int NumVC    = 2,
  localparam int VcWidth = (NumVC > 1) ? $clog2(NumVC) : 1
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  // local winners aimed at this output
  input  logic [NumPorts-1:0]               req_v_i,
  input  logic [NumPorts-1:0][VcWidth-1:0]  req_vc_i,
  output logic                              grant_v_o,
  output logic [NumPorts-1:0]               grant_in_oh_o,
  output logic [VcWidth-1:0]                grant_vc_o
);

  localparam int InWidth = $clog2(NumPorts);

  // last granted input
  logic [InWidth-1:0] ptr_q;
  logic [InWidth-1:0] winner;

  always_comb begin
    int idx;
    grant_v_o = 1'b0;
    winner    = '0;
    for (int i = 1; i <= NumPorts; i++) begin
      idx = (int'(ptr_q) + i) % NumPorts;
      if (!grant_v_o && req_v_i[idx]) begin
        grant_v_o = 1'b1;
        winner    = InWidth'(idx);
      end
    end
  end

  always_comb begin
    grant_in_oh_o = '0;
    if (grant_v_o) begin
      grant_in_oh_o[winner] = 1'b1;
    end
    grant_vc_o = req_vc_i[winner];
  end

  // every grant moves priority past the winner
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q <= InWidth'(NumPorts - 1);
    end else if (grant_v_o) begin
      ptr_q <= winner;
    end
  end

endmodule

`default_nettype wire

//--- design/vc_output_port.sv
// router output port with downstream credit counters and the switch-traversal register
`timescale 1ns/1ps
`default_nettype none

module vc_output_port #(
  parameter int NumVC         = 2,
  parameter int VCDepth       = 2,
  parameter int CoordWidth    = 3,
  parameter int PayloadWidth  = 16,
  localparam int VcWidth      = (NumVC > 1) ? $clog2(NumVC) : 1
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // global grant for this output
  input  logic                      grant_v_i,
  input  logic [VcWidth-1:0]        grant_vc_i,
  // flit selected by the crossbar
  input  logic [CoordWidth-1:0]     flit_dst_x_i,
  input  logic [CoordWidth-1:0]     flit_dst_y_i,
  input  logic [PayloadWidth-1:0]   flit_payload_i,
  // credit from downstream
  input  logic                      credit_v_i,
  input  logic [VcWidth-1:0]        credit_vc_i,
  output logic [NumVC-1:0]          credit_avail_o,
  // registered flit to downstream
  output logic                      data_v_o,
  output logic [VcWidth-1:0]        data_vc_o,
  output logic [CoordWidth-1:0]     data_dst_x_o,
  output logic [CoordWidth-1:0]     data_dst_y_o,
  output logic [PayloadWidth-1:0]   data_payload_o
);

  localparam int CntWidth = $clog2(VCDepth + 1);

  // free slots downstream, per VC
  logic [CntWidth-1:0] credit_cnt_q [NumVC];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int v = 0; v < NumVC; v++) begin
        credit_cnt_q[v] <= CntWidth'(VCDepth);
      end
    end else begin
      for (int v = 0; v < NumVC; v++) begin
        // return and consume on the same VC cancel out
        if (credit_v_i && credit_vc_i == VcWidth'(v) &&
            !(grant_v_i && grant_vc_i == VcWidth'(v))) begin
          credit_cnt_q[v] <= credit_cnt_q[v] + 1'b1;
        end else if (grant_v_i && grant_vc_i == VcWidth'(v) &&
                     !(credit_v_i && credit_vc_i == VcWidth'(v))) begin
          credit_cnt_q[v] <= credit_cnt_q[v] - 1'b1;
        end
      end
    end
  end

  always_comb begin
    for (int v = 0; v < NumVC; v++) begin
      credit_avail_o[v] = (credit_cnt_q[v] != '0);
    end
  end

  // switch traversal, valid strobe
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      data_v_o <= 1'b0;
    end else begin
      data_v_o <= grant_v_i;
    end
  end

  // switch traversal, flit fields
  always_ff @(posedge clk_i) begin
    if (grant_v_i) begin
      data_vc_o      <= grant_vc_i;
      data_dst_x_o   <= flit_dst_x_i;
      data_dst_y_o   <= flit_dst_y_i;
      data_payload_o <= flit_payload_i;
    end
  end

endmodule

`default_nettype wire

//--- design/vc_router.sv
// five-port virtual-channel router with XY routing and credit-based flow control
`timescale 1ns/1ps
`default_nettype none

module vc_router import vc_router_pkg::*; #(
  parameter int NumVC         = 2,
  parameter int VCDepth       = 2,
  parameter int CoordWidth    = 3,
  parameter int PayloadWidth  = 16,
  localparam int VcWidth      = (NumVC > 1) ? $clog2(NumVC) : 1
) (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  // own coordinate
  input  logic [CoordWidth-1:0]                     xy_id_x_i,
  input  logic [CoordWidth-1:0]                     xy_id_y_i,
  // incoming flits and credits back upstream
  input  logic [NumPorts-1:0]                       data_v_i,
  input  logic [NumPorts-1:0][VcWidth-1:0]          data_vc_i,
  input  logic [NumPorts-1:0][CoordWidth-1:0]       data_dst_x_i,
  input  logic [NumPorts-1:0][CoordWidth-1:0]       data_dst_y_i,
  input  logic [NumPorts-1:0][PayloadWidth-1:0]     data_payload_i,
  output logic [NumPorts-1:0]                       credit_v_o,
  output logic [NumPorts-1:0][VcWidth-1:0]          credit_vc_o,
  // outgoing flits and credits from downstream
  output logic [NumPorts-1:0]                       data_v_o,
  output logic [NumPorts-1:0][VcWidth-1:0]          data_vc_o,
  output logic [NumPorts-1:0][CoordWidth-1:0]       data_dst_x_o,
  output logic [NumPorts-1:0][CoordWidth-1:0]       data_dst_y_o,
  output logic [NumPorts-1:0][PayloadWidth-1:0]     data_payload_o,
  input  logic [NumPorts-1:0]                       credit_v_i,
  input  logic [NumPorts-1:0][VcWidth-1:0]          credit_vc_i
);

  // ==============================
  // internal signals
  // ==============================

  // heads, indexed by input port then VC
  logic [NumPorts-1:0][NumVC-1:0]                    head_v;
  route_dir_e [NumPorts-1:0][NumVC-1:0]              head_dir;
  logic [NumPorts-1:0][NumVC-1:0][CoordWidth-1:0]    head_dst_x;
  logic [NumPorts-1:0][NumVC-1:0][CoordWidth-1:0]    head_dst_y;
  logic [NumPorts-1:0][NumVC-1:0][PayloadWidth-1:0]  head_payload;

  // credit availability, indexed by output port then VC
  logic [NumPorts-1:0][NumVC-1:0]                    credit_avail;

  // local winners, indexed by input port
  logic [NumPorts-1:0]                               loc_req_v;
  logic [NumPorts-1:0][NumPorts-1:0]                 loc_req_dir_oh;
  logic [NumPorts-1:0][VcWidth-1:0]                  loc_req_vc;

  // local requests regrouped per output
  logic [NumPorts-1:0][NumPorts-1:0]                 req_v_per_out;

  // global grants, indexed by output port
  logic [NumPorts-1:0]                               grant_v;
  logic [NumPorts-1:0][NumPorts-1:0]                 grant_in_oh;
  logic [NumPorts-1:0][VcWidth-1:0]                  grant_vc;

  // pops back to the inputs
  logic [NumPorts-1:0]                               pop;

  // crossbar outputs, indexed by output port
  logic [NumPorts-1:0][CoordWidth-1:0]               xbar_dst_x;
  logic [NumPorts-1:0][CoordWidth-1:0]               xbar_dst_y;
  logic [NumPorts-1:0][PayloadWidth-1:0]             xbar_payload;

  // ==============================
  // input ports and local SA
  // ==============================

  for (genvar in_port = 0; in_port < NumPorts; in_port++) begin : gen_in
    vc_input_port #(
      .NumVC        (NumVC),
      .VCDepth      (VCDepth),
      .CoordWidth   (CoordWidth),
      .PayloadWidth (PayloadWidth)
    ) i_input_port (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .data_v_i       (data_v_i[in_port]),
      .data_vc_i      (data_vc_i[in_port]),
      .data_dst_x_i   (data_dst_x_i[in_port]),
      .data_dst_y_i   (data_dst_y_i[in_port]),
      .data_payload_i (data_payload_i[in_port]),
      .xy_id_x_i      (xy_id_x_i),
      .xy_id_y_i      (xy_id_y_i),
      .pop_i          (pop[in_port]),
      .pop_vc_i       (loc_req_vc[in_port]),
      .credit_v_o     (credit_v_o[in_port]),
      .credit_vc_o    (credit_vc_o[in_port]),
      .head_v_o       (head_v[in_port]),
      .head_dir_o     (head_dir[in_port]),
      .head_dst_x_o   (head_dst_x[in_port]),
      .head_dst_y_o   (head_dst_y[in_port]),
      .head_payload_o (head_payload[in_port])
    );

    // the granted flit is always this port's local winner
    vc_sa_local #(
      .NumVC (NumVC)
    ) i_sa_local (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .head_v_i       (head_v[in_port]),
      .head_dir_i     (head_dir[in_port]),
      .credit_avail_i (credit_avail),
      .granted_i      (pop[in_port]),
      .req_v_o        (loc_req_v[in_port]),
      .req_dir_oh_o   (loc_req_dir_oh[in_port]),
      .req_vc_o       (loc_req_vc[in_port])
    );
  end

  // ==============================
  // request transpose, grant return, crossbar
  // ==============================

  always_comb begin
    for (int o = 0; o < NumPorts; o++) begin
      for (int i = 0; i < NumPorts; i++) begin
        req_v_per_out[o][i] = loc_req_v[i] && loc_req_dir_oh[i][o];
      end
    end
  end

  // at most one output grants a given input, its request is one-hot
  always_comb begin
    for (int i = 0; i < NumPorts; i++) begin
      pop[i] = 1'b0;
      for (int o = 0; o < NumPorts; o++) begin
        pop[i] = pop[i] | grant_in_oh[o][i];
      end
    end
  end

  // select the granted input's head on the granted VC
  always_comb begin
    for (int o = 0; o < NumPorts; o++) begin
      xbar_dst_x[o]   = '0;
      xbar_dst_y[o]   = '0;
      xbar_payload[o] = '0;
      for (int i = 0; i < NumPorts; i++) begin
        if (grant_in_oh[o][i]) begin
          xbar_dst_x[o]   = head_dst_x[i][grant_vc[o]];
          xbar_dst_y[o]   = head_dst_y[i][grant_vc[o]];
          xbar_payload[o] = head_payload[i][grant_vc[o]];
        end
      end
    end
  end

  // ==============================
  // global SA and output ports
  // ==============================

  for (genvar out_port = 0; out_port < NumPorts; out_port++) begin : gen_out
    vc_sa_global #(
      .NumVC (NumVC)
    ) i_sa_global (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .req_v_i       (req_v_per_out[out_port]),
      .req_vc_i      (loc_req_vc),
      .grant_v_o     (grant_v[out_port]),
      .grant_in_oh_o (grant_in_oh[out_port]),
      .grant_vc_o    (grant_vc[out_port])
    );

    vc_output_port #(
      .NumVC        (NumVC),
      .VCDepth      (VCDepth),
      .CoordWidth   (CoordWidth),
      .PayloadWidth (PayloadWidth)
    ) i_output_port (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .grant_v_i      (grant_v[out_port]),
      .grant_vc_i     (grant_vc[out_port]),
      .flit_dst_x_i   (xbar_dst_x[out_port]),
      .flit_dst_y_i   (xbar_dst_y[out_port]),
      .flit_payload_i (xbar_payload[out_port]),
      .credit_v_i     (credit_v_i[out_port]),
      .credit_vc_i    (credit_vc_i[out_port]),
      .credit_avail_o (credit_avail[out_port]),
      .data_v_o       (data_v_o[out_port]),
      .data_vc_o      (data_vc_o[out_port]),
      .data_dst_x_o   (data_dst_x_o[out_port]),
      .data_dst_y_o   (data_dst_y_o[out_port]),
      .data_payload_o (data_payload_o[out_port])
    );
  end

endmodule

`default_nettype wire

//--- tb/tb_vc_router_chk.sv
// bound checker for output credit counters, grant one-hot and quiet outputs in reset
`timescale 1ns/1ps
`default_nettype none

module tb_vc_router_chk import vc_router_pkg::*; #(
  parameter int NumVC    = 2,
  parameter int VCDepth  = 2,
  localparam int VcWidth = (NumVC > 1) ? $clog2(NumVC) : 1
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic [NumPorts-1:0]               grant_v_i,
  input  logic [NumPorts-1:0][NumPorts-1:0] grant_in_oh_i,
  input  logic [NumPorts-1:0][VcWidth-1:0]  grant_vc_i,
  input  logic [NumPorts-1:0][NumVC-1:0]    credit_avail_i,
  input  logic [NumPorts-1:0]               credit_v_i,
  input  logic [NumPorts-1:0][VcWidth-1:0]  credit_vc_i,
  input  logic [NumPorts-1:0]               data_v_i,
  input  logic [NumPorts-1:0][VcWidth-1:0]  data_vc_i,
  input  logic [NumPorts-1:0]               credit_up_v_i
);

  // shadow of every output VC credit counter
  int cnt_q [NumPorts][NumVC];

  // grants regrouped per input port
  logic [NumPorts-1:0][NumPorts-1:0] grant_by_in;

  always_comb begin
    for (int i = 0; i < NumPorts; i++) begin
      for (int o = 0; o < NumPorts; o++) begin
        grant_by_in[i][o] = grant_in_oh_i[o][i];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int o = 0; o < NumPorts; o++) begin
        for (int v = 0; v < NumVC; v++) begin
          cnt_q[o][v] <= VCDepth;
        end
      end
    end else begin
      for (int o = 0; o < NumPorts; o++) begin
        for (int v = 0; v < NumVC; v++) begin
          cnt_q[o][v] <= cnt_q[o][v]
            + ((credit_v_i[o] && credit_vc_i[o] == VcWidth'(v)) ? 1 : 0)
            - ((grant_v_i[o] && grant_vc_i[o] == VcWidth'(v)) ? 1 : 0);
        end
      end
    end
  end

  // registered outputs stay low while reset is held
  a_reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |-> (data_v_i == '0 && credit_up_v_i == '0))
    else $error("data_v_o or credit_v_o high during reset");

  for (genvar o = 0; o < NumPorts; o++) begin : gen_port
    // one input per output, no input popped by two outputs, strobe matches the grant
    a_grant_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(grant_in_oh_i[o]) && $onehot0(grant_by_in[o]) &&
      (grant_v_i[o] == |grant_in_oh_i[o]))
      else $error("grant of output %0d or to input %0d is not one-hot", o, o);

    // a grant consumes a credit that exists
    a_grant_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      grant_v_i[o] |-> credit_avail_i[o][grant_vc_i[o]])
      else $error("output %0d granted on a VC without credit", o);

    // every outgoing flit was granted one edge earlier on the same VC
    a_data_granted: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      data_v_i[o] |-> ($past(grant_v_i[o]) && data_vc_i[o] == $past(grant_vc_i[o])))
      else $error("output %0d sent a flit without a grant", o);

    for (genvar v = 0; v < NumVC; v++) begin : gen_vc
      a_cnt_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cnt_q[o][v] >= 0 && cnt_q[o][v] <= VCDepth)
        else $error("credit count of output %0d vc %0d out of range", o, v);

      a_cnt_avail: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        credit_avail_i[o][v] == (cnt_q[o][v] != 0))
        else $error("credit_avail of output %0d vc %0d disagrees with count", o, v);
    end
  end

endmodule

bind vc_router tb_vc_router_chk #(
  .NumVC   (NumVC),
  .VCDepth (VCDepth)
) u_chk (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .grant_v_i      (grant_v),
  .grant_in_oh_i  (grant_in_oh),
  .grant_vc_i     (grant_vc),
  .credit_avail_i (credit_avail),
  .credit_v_i     (credit_v_i),
  .credit_vc_i    (credit_vc_i),
  .data_v_i       (data_v_o),
  .data_vc_i      (data_vc_o),
  .credit_up_v_i  (credit_v_o)
);

`default_nettype wire

//--- tb/tb_vc_router.sv
// testbench for the five-port VC router with record-file stimulus and credit models
`timescale 1ns/1ps
`default_nettype none

module tb_vc_router import vc_router_pkg::*; ();

  localparam int NumVC        = 2;
  localparam int VCDepth      = 2;
  localparam int CoordWidth   = 3;
  localparam int PayloadWidth = 16;
  localparam int VcWidth      = 1;
  localparam int MaxRec       = 64;
  localparam int ClkPeriod    = 100;
  localparam int DriveDelay   = 10;
  // output E gets no downstream credits inside this window
  localparam int HoldPort     = int'(E);
  localparam int HoldStart    = 8;
  localparam int HoldEnd      = 70;

  logic                                  clk;
  logic                                  rst_n;
  logic [CoordWidth-1:0]                 xy_x;
  logic [CoordWidth-1:0]                 xy_y;
  logic [NumPorts-1:0]                   in_v;
  logic [NumPorts-1:0][VcWidth-1:0]      in_vc;
  logic [NumPorts-1:0][CoordWidth-1:0]   in_dst_x;
  logic [NumPorts-1:0][CoordWidth-1:0]   in_dst_y;
  logic [NumPorts-1:0][PayloadWidth-1:0] in_payload;
  logic [NumPorts-1:0]                   up_credit_v;
  logic [NumPorts-1:0][VcWidth-1:0]      up_credit_vc;
  logic [NumPorts-1:0]                   out_v;
  logic [NumPorts-1:0][VcWidth-1:0]      out_vc;
  logic [NumPorts-1:0][CoordWidth-1:0]   out_dst_x;
  logic [NumPorts-1:0][CoordWidth-1:0]   out_dst_y;
  logic [NumPorts-1:0][PayloadWidth-1:0] out_payload;
  logic [NumPorts-1:0]                   dn_credit_v;
  logic [NumPorts-1:0][VcWidth-1:0]      dn_credit_vc;

  // record word: port, vc, dst x, dst y, payload, expected output
  logic [35:0] stim_mem [MaxRec];

  int   num_rec;
  int   port_q    [NumPorts][$];
  // sent and not yet delivered, per source port and VC
  int   sb_q      [NumPorts][NumVC][$];
  // VCs owed a credit by the downstream model, per output
  int   ret_q     [NumPorts][$];
  int   ret_wait  [NumPorts];
  int   up_cred   [NumPorts][NumVC];
  int   owed      [NumPorts][NumVC];
  int   sent_cnt  [NumPorts][NumVC];
  int   crd_cnt   [NumPorts][NumVC];
  int   cycle;
  int   limit;
  int   err_cnt;
  logic [7:0] lfsr;

  vc_router #(
    .NumVC        (NumVC),
    .VCDepth      (VCDepth),
    .CoordWidth   (CoordWidth),
    .PayloadWidth (PayloadWidth)
  ) DUT (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .xy_id_x_i      (xy_x),
    .xy_id_y_i      (xy_y),
    .data_v_i       (in_v),
    .data_vc_i      (in_vc),
    .data_dst_x_i   (in_dst_x),
    .data_dst_y_i   (in_dst_y),
    .data_payload_i (in_payload),
    .credit_v_o     (up_credit_v),
    .credit_vc_o    (up_credit_vc),
    .data_v_o       (out_v),
    .data_vc_o      (out_vc),
    .data_dst_x_o   (out_dst_x),
    .data_dst_y_o   (out_dst_y),
    .data_payload_o (out_payload),
    .credit_v_i     (dn_credit_v),
    .credit_vc_i    (dn_credit_vc)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(ClkPeriod / 2) clk = ~clk;
    end
  end

  // ==============================
  // helpers
  // ==============================

  // 8-bit Fibonacci LFSR, taps 8 6 5 4
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  // 0 to 3 cycles, one step per bit
  function automatic int rand_delay();
    int d;
    d = 0;
    for (int b = 0; b < 2; b++) begin
      lfsr = lfsr_next(lfsr);
      d = (d << 1) | int'(lfsr[0]);
    end
    return d;
  endfunction

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic compare(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("FAIL t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
      err_cnt++;
      abort_run();
    end
  endtask

  task automatic load_records();
    logic [35:0] w;
    for (int i = 0; i < MaxRec; i++) begin
      stim_mem[i] = '1;
    end
    $readmemh("tb/vc_router_input.txt", stim_mem);
    xy_x = stim_mem[0][6:4];
    xy_y = stim_mem[0][2:0];
    num_rec = 0;
    for (int i = 1; i < MaxRec; i++) begin
      w = stim_mem[i];
      if (w == '1) begin
        break;
      end
      if (int'(w[35:32]) >= NumPorts || int'(w[31:28]) >= NumVC) begin
        $display("ERROR: record %0d names a port or VC that does not exist", i);
        err_cnt++;
        abort_run();
      end else begin
        port_q[int'(w[35:32])].push_back(i);
        num_rec++;
      end
    end
  endtask

  function automatic bit all_done();
    for (int p = 0; p < NumPorts; p++) begin
      if (port_q[p].size() != 0 || ret_q[p].size() != 0) begin
        return 1'b0;
      end
      for (int v = 0; v < NumVC; v++) begin
        if (sb_q[p][v].size() != 0) begin
          return 1'b0;
        end
      end
    end
    return 1'b1;
  endfunction

  // ==============================
  // upstream, downstream and scoreboard
  // ==============================

  task automatic collect_outputs();
    logic [35:0] w;
    int v;
    int sp;
    int sv;
    int idx;
    for (int p = 0; p < NumPorts; p++) begin
      if (up_credit_v[p]) begin
        v = int'(up_credit_vc[p]);
        up_cred[p][v]++;
        crd_cnt[p][v]++;
      end
    end
    for (int o = 0; o < NumPorts; o++) begin
      if (out_v[o]) begin
        v  = int'(out_vc[o]);
        sp = int'(out_payload[o][15:12]);
        sv = int'(out_payload[o][11:8]);
        if (sp >= NumPorts || sv >= NumVC || sb_q[sp][sv].size() == 0) begin
          $display("ERROR t=%0t: unexpected flit on output %0d, payload %0h",
                   $time, o, out_payload[o]);
          err_cnt++;
          abort_run();
        end else if (owed[o][v] >= VCDepth) begin
          $display("ERROR t=%0t: output %0d sent on VC %0d without a credit", $time, o, v);
          err_cnt++;
          abort_run();
        end else begin
          idx = sb_q[sp][sv].pop_front();
          w = stim_mem[idx];
          compare($sformatf("data_v_o port, record %0d", idx), o, int'(w[3:0]));
          compare($sformatf("data_vc_o[%0d]", o), v, int'(w[31:28]));
          compare($sformatf("data_dst_x_o[%0d]", o), int'(out_dst_x[o]), int'(w[27:24]));
          compare($sformatf("data_dst_y_o[%0d]", o), int'(out_dst_y[o]), int'(w[23:20]));
          compare($sformatf("data_payload_o[%0d]", o), int'(out_payload[o]), int'(w[19:4]));
          owed[o][v]++;
          ret_q[o].push_back(v);
        end
      end
    end
  endtask

  task automatic return_credits();
    int v;
    dn_credit_v = '0;
    for (int o = 0; o < NumPorts; o++) begin
      if (ret_q[o].size() > 0 &&
          !(o == HoldPort && cycle >= HoldStart && cycle < HoldEnd)) begin
        if (ret_wait[o] > 0) begin
          ret_wait[o]--;
        end else begin
          v = ret_q[o].pop_front();
          dn_credit_v[o]  = 1'b1;
          dn_credit_vc[o] = VcWidth'(v);
          owed[o][v]--;
          ret_wait[o] = rand_delay();
        end
      end
    end
  endtask

  // first pending record whose VC holds a credit, order within a VC is kept
  task automatic send_flits();
    logic [35:0] w;
    int sel;
    int v;
    in_v = '0;
    for (int p = 0; p < NumPorts; p++) begin
      sel = -1;
      for (int k = 0; k < port_q[p].size(); k++) begin
        if (sel < 0 && up_cred[p][int'(stim_mem[port_q[p][k]][31:28])] > 0) begin
          sel = k;
        end
      end
      if (sel >= 0) begin
        w = stim_mem[port_q[p][sel]];
        v = int'(w[31:28]);
        in_v[p]       = 1'b1;
        in_vc[p]      = VcWidth'(v);
        in_dst_x[p]   = CoordWidth'(w[27:24]);
        in_dst_y[p]   = CoordWidth'(w[23:20]);
        in_payload[p] = w[19:4];
        up_cred[p][v]--;
        sent_cnt[p][v]++;
        sb_q[p][v].push_back(port_q[p][sel]);
        port_q[p].delete(sel);
      end
    end
  endtask

  // ==============================
  // main sequence
  // ==============================

  initial begin
    rst_n        = 1'b0;
    xy_x         = '0;
    xy_y         = '0;
    in_v         = '0;
    in_vc        = '0;
    in_dst_x     = '0;
    in_dst_y     = '0;
    in_payload   = '0;
    dn_credit_v  = '0;
    dn_credit_vc = '0;
    lfsr         = 8'd11;
    cycle        = 0;
    err_cnt      = 0;
    for (int p = 0; p < NumPorts; p++) begin
      ret_wait[p] = 0;
      for (int v = 0; v < NumVC; v++) begin
        up_cred[p][v]  = VCDepth;
        owed[p][v]     = 0;
        sent_cnt[p][v] = 0;
        crd_cnt[p][v]  = 0;
      end
    end
    load_records();
    limit = 20 * num_rec + 200;
    repeat (5) @(posedge clk);
    #DriveDelay rst_n = 1'b1;

    while (!all_done()) begin
      @(posedge clk);
      #DriveDelay;
      cycle++;
      if (cycle > limit) begin
        $display("ERROR t=%0t: timeout after %0d cycles, flits still in flight", $time, cycle);
        abort_run();
      end else begin
        collect_outputs();
        // starved output must have filled every downstream VC slot
        if (cycle == HoldEnd - 1) begin
          for (int v = 0; v < NumVC; v++) begin
            compare($sformatf("flits held at output %0d vc %0d", HoldPort, v),
                    owed[HoldPort][v], VCDepth);
          end
        end
        return_credits();
        send_flits();
      end
    end

    // every flit is out, so the router must stay quiet
    @(posedge clk);
    #DriveDelay;
    compare("data_v_o after drain", int'(out_v), 0);
    compare("credit_v_o after drain", int'(up_credit_v), 0);
    for (int p = 0; p < NumPorts; p++) begin
      for (int v = 0; v < NumVC; v++) begin
        compare($sformatf("credit_v_o[%0d] pulses vc %0d", p, v), crd_cnt[p][v], sent_cnt[p][v]);
      end
    end
    if (err_cnt == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

`default_nettype wire

//--- all.f
design/vc_router_pkg.sv
design/vc_input_port.sv
design/vc_sa_local.sv
design/vc_sa_global.sv
design/vc_output_port.sv
design/vc_router.sv
tb/tb_vc_router_chk.sv
tb/tb_vc_router.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert -j 0 --top-module tb_vc_router -f all.f -o tb_vc_router \
  && { out=$(./obj_dir/tb_vc_router 2>&1); echo "$out"; echo "$out" | grep -q "^PASS: all tests$"; } \
  && echo "router simulation passed" \
  || { echo "router simulation failed"; exit 1; }

//--- tb/vc_router_input.txt
// word 0: router coordinate, x in bits 6:4, y in bits 2:0
// records, 9 hex digits: in port, vc, dst x, dst y, payload (4 digits), expected out port
// ports N=0 E=1 S=2 W=3 L=4, payload = source port, vc, sequence number
000000022
// one flit per XY direction, own coordinate (2,2)
002200014
102510020
215121031
400640043
012001052
312231064
112011072
307330081
// same source and VC, sequence order towards N, then one to E
402440090
4024400a0
4024400b0
4024400c0
4062400d1
// four inputs N S W L all aimed at E
0050000e1
0167010f1
003300101
204420111
217021121
203220131
305530141
314131151
316631161
413041171
407740181
415241191
// traffic to other outputs while E is starved of credits
1002101a3
1117111b3
1021101c2
0122011d4
2026201e0
2127211f0
// end of records
fffffffff
